/* dv/tb_clkgen.sv */
// ==============================
// Testbench clock and reset
// ==============================
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD  = 50,  // 100 ns clock
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;  // Released on a rising edge
    end

endmodule

/* dv/tb_toccata.sv */
// ==============================
// Toccata playback testbench
// Random bus traffic checked against a register and audio model
// ==============================
`timescale 1ns/1ps

module tb_toccata;
    import toccata_pkg::*;

    localparam int SAMPLE_DIV    = 16;
    localparam int FIFO_DEPTH    = 32;
    localparam int FRAME_TIMEOUT = 20 * SAMPLE_DIV;  // Cycles allowed per output frame
    localparam int IRQ_TIMEOUT   = 40;

    localparam logic [15:0] ADDR_STATUS = 16'h0000;
    localparam logic [15:0] ADDR_FIFO   = 16'h2000;
    localparam logic [15:0] ADDR_INDEX  = 16'h6000;
    localparam logic [15:0] ADDR_CODEC  = 16'h6800;

    logic        clk;
    logic        rst;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic [15:1] addr;
    logic        rd;
    logic        hwr;
    logic        lwr;
    logic        sel;
    logic        toc_int;
    sample_t     out_left;
    sample_t     out_right;

    integer seed = 32'hd17a9045;
    int     checks;
    int     errors;
    int     test_errors;  // Errors before the current test

    // ==============================
    // Model state
    // ==============================
    logic [7:0]  model_regs [16];
    logic [7:0]  model_index;
    logic [7:0]  model_status;
    logic [7:0]  model_irq;
    logic [7:0]  byte_q [$];  // FIFO contents, oldest first
    logic [15:0] word_q [$];  // Host writes still to issue
    sample_t     last_l;      // Last presented frame, before volume
    sample_t     last_r;
    sample_t     prev_l;      // Outputs expected right now
    sample_t     prev_r;

    tb_clkgen i_clkgen (
        .clk (clk),
        .rst (rst)
    );

    toccata_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .SAMPLE_DIV (SAMPLE_DIV)
    ) i_toccata_top (
        .clk       (clk),
        .rst       (rst),
        .data_in   (data_in),
        .data_out  (data_out),
        .addr      (addr),
        .rd        (rd),
        .hwr       (hwr),
        .lwr       (lwr),
        .sel       (sel),
        .toc_int   (toc_int),
        .out_left  (out_left),
        .out_right (out_right)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        $display("%-32s %s", name, (errors == test_errors) ? "ok" : "failed");
        test_errors = errors;
    endtask

    // Offset binary byte to signed sample, (b - 128) * 256
    function automatic sample_t widen8(input logic [7:0] b);
        int v;
        v = (int'(b) - 128) * 256;
        return v[15:0];
    endfunction

    // Mute in bit 7, shift by attenuation bits 5 to 2
    function automatic sample_t scaled(input sample_t s, input logic [7:0] dac);
        int v;
        v = s;  // Sign extends
        v = v >>> dac[5:2];
        return dac[7] ? 16'sd0 : v[15:0];
    endfunction

    function automatic int frame_bytes();
        int n;
        n = model_regs[REG_FORMAT][6] ? 2 : 1;  // Bytes per channel
        if (model_regs[REG_FORMAT][4]) n = n * 2;
        return n;
    endfunction

    function automatic logic [7:0] model_codec(input logic [3:0] idx);
        logic [7:0] v;
        v = model_regs[idx];
        if (idx == 4'd11) v[6] = (byte_q.size() == 0);  // Underrun mirror
        return v;
    endfunction

    // Bytes packed oldest in bits 7:0
    task automatic decode_frame(input logic [31:0] fb, output sample_t l, output sample_t r);
        if (model_regs[REG_FORMAT][6]) begin
            l = fb[15:0];                                  // Low byte first
            r = model_regs[REG_FORMAT][4] ? fb[31:16] : l;
        end else begin
            l = widen8(fb[7:0]);
            r = model_regs[REG_FORMAT][4] ? widen8(fb[15:8]) : l;
        end
    endtask

    task automatic pop_frame(output sample_t l, output sample_t r);
        logic [31:0] fb;
        fb = '0;
        for (int k = 0; k < frame_bytes(); k++) begin
            if (byte_q.size() > 0) fb[8*k +: 8] = byte_q.pop_front();
        end
        decode_frame(fb, l, r);
    endtask

    // ==============================
    // Bus access
    // ==============================
    task automatic bus_cycle(input logic [15:0] byte_addr, input logic [15:0] wdata,
                             input logic do_rd, input logic do_lwr, input logic do_hwr,
                             output logic [15:0] rdata);
        @(posedge clk);
        addr    <= byte_addr[15:1];
        data_in <= wdata;
        sel     <= 1'b1;
        rd      <= do_rd;
        lwr     <= do_lwr;
        hwr     <= do_hwr;
        repeat (2) @(posedge clk);  // Two cycles with sel
        sel <= 1'b0;
        rd  <= 1'b0;
        lwr <= 1'b0;
        hwr <= 1'b0;
        @(negedge clk);             // data_out holds the read value here
        rdata = data_out;
    endtask

    task automatic read_expect(input logic [15:0] byte_addr, input logic [15:0] expected,
                               input string name);
        logic [15:0] rdata;
        bus_cycle(byte_addr, 16'h0000, 1'b1, 1'b0, 1'b0, rdata);
        check_value(name, expected, rdata);
    endtask

    task automatic write_index(input logic [7:0] value);
        logic [15:0] unused;
        bus_cycle(ADDR_INDEX, {8'h00, value}, 1'b0, 1'b1, 1'b0, unused);
        model_index = value;
    endtask

    task automatic write_codec(input logic [7:0] index_val, input logic [7:0] value);
        logic [15:0] unused;
        write_index(index_val);
        bus_cycle(ADDR_CODEC, {8'h00, value}, 1'b0, 1'b1, 1'b0, unused);
        if (index_val[3:0] != 4'd12) model_regs[index_val[3:0]] = value;  // 12 is read only
    endtask

    task automatic write_status(input logic [7:0] value);
        logic [15:0] unused;
        logic        play_on;
        bus_cycle(ADDR_STATUS, {8'h00, value}, 1'b0, 1'b1, 1'b0, unused);
        play_on = value[STATUS_FIFO_CODEC] & value[STATUS_FIFO_PLAY];
        if (value[STATUS_RESET]) begin  // Card reset
            model_status = 8'h00;
            model_irq    = 8'h80;
            model_regs[REG_IFACE][0] = 1'b0;
            byte_q.delete();
        end else begin
            model_status = value;
            if (value == 8'h01) begin
                byte_q.delete();
                model_irq = 8'h80;
            end
            model_regs[REG_IFACE][0]     = play_on;
            model_regs[REG_LEFT_DAC][7]  = !play_on;
            model_regs[REG_RIGHT_DAC][7] = !play_on;
        end
    endtask

    // ==============================
    // Audio stimulus and checking
    // ==============================
    // Random frames, each differing from the one before at the outputs
    task automatic make_frames(input int count);
        logic [31:0] fb;
        sample_t     l;
        sample_t     r;
        sample_t     gl;
        sample_t     gr;
        int          n;
        int          tries;
        n  = frame_bytes();
        gl = prev_l;
        gr = prev_r;
        repeat (count) begin
            tries = 0;
            do begin
                fb = $random(seed);
                decode_frame(fb, l, r);
                tries++;
            end while (scaled(l, model_regs[REG_LEFT_DAC]) == gl &&
                       scaled(r, model_regs[REG_RIGHT_DAC]) == gr && tries < 64);
            gl = scaled(l, model_regs[REG_LEFT_DAC]);
            gr = scaled(r, model_regs[REG_RIGHT_DAC]);
            for (int k = 0; k < n; k++) byte_q.push_back(fb[8*k +: 8]);
            if (model_regs[REG_FORMAT][6]) begin
                for (int k = 0; k < n / 2; k++) word_q.push_back(fb[16*k +: 16]);
            end else begin
                for (int k = 0; k < n; k++) word_q.push_back({8'h00, fb[8*k +: 8]});
            end
        end
    endtask

    task automatic feed_fifo();
        logic [15:0] unused;
        logic [15:0] word;
        logic        word_mode;
        word_mode = model_regs[REG_FORMAT][6];  // hwr too for 16-bit words
        while (word_q.size() > 0) begin
            word = word_q.pop_front();
            bus_cycle(ADDR_FIFO, word, 1'b0, 1'b1, word_mode, unused);
        end
    endtask

    task automatic check_frames(input int count);
        sample_t l;
        sample_t r;
        int      waited;
        for (int f = 0; f < count; f++) begin
            waited = 0;
            @(negedge clk);
            while (out_left === prev_l && out_right === prev_r && waited < FRAME_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= FRAME_TIMEOUT) begin
                $display("Timeout at %0t: output frame %0d never arrived", $time, f);
                errors++;
            end
            pop_frame(l, r);
            last_l = l;
            last_r = r;
            prev_l = scaled(l, model_regs[REG_LEFT_DAC]);
            prev_r = scaled(r, model_regs[REG_RIGHT_DAC]);
            check_value("out_left", prev_l, out_left);
            check_value("out_right", prev_r, out_right);
        end
    endtask

    // Held frame after a volume or mute change
    task automatic sync_outputs();
        prev_l = scaled(last_l, model_regs[REG_LEFT_DAC]);
        prev_r = scaled(last_r, model_regs[REG_RIGHT_DAC]);
        check_value("out_left", prev_l, out_left);
        check_value("out_right", prev_r, out_right);
    endtask

    task automatic wait_toc_int(input logic level);
        int waited;
        waited = 0;
        while (toc_int !== level && waited < IRQ_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (toc_int !== level) begin
            $display("Timeout at %0t: toc_int never went to %0b", $time, level);
            errors++;
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int         waited;
        logic [7:0] idx;
        logic [7:0] val;
        data_in <= '0;
        addr    <= '0;
        rd      <= 1'b0;
        hwr     <= 1'b0;
        lwr     <= 1'b0;
        sel     <= 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        for (int i = 0; i < 16; i++) model_regs[i] = 8'h00;
        for (int i = 3; i <= 7; i++) model_regs[i] = 8'h80;  // Muted inputs and DACs
        model_regs[9]  = 8'h10;
        model_regs[12] = 8'h0a;
        model_index  = 8'h40;
        model_status = 8'h00;
        model_irq    = 8'h80;
        last_l = '0;
        last_r = '0;
        prev_l = '0;
        prev_r = '0;

        waited = 0;
        while (rst !== 1'b0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset was never released");
            errors++;
        end
        @(negedge clk);

        // 1 reset state
        check_value("toc_int", 32'd0, toc_int);
        check_value("data_out", 32'd0, data_out);
        check_value("out_left", 32'd0, out_left);
        check_value("out_right", 32'd0, out_right);
        read_expect(ADDR_INDEX, {8'h00, model_index}, "index");
        write_index(8'h09);
        read_expect(ADDR_CODEC, {8'h00, model_codec(4'd9)}, "codec_reg9");
        read_expect(ADDR_STATUS, {model_irq, model_irq}, "irq");
        end_test("reset values");

        // 2 random register traffic, upper index bits random too
        repeat (10) begin
            idx = $random(seed);
            val = $random(seed);
            write_codec(idx, val);
            read_expect(ADDR_INDEX, {8'h00, model_index}, "index");
            read_expect(ADDR_CODEC, {8'h00, model_codec(idx[3:0])}, "codec_reg");
        end
        val = $random(seed);
        write_codec(8'h0c, val);
        read_expect(ADDR_CODEC, {8'h00, model_codec(4'd12)}, "codec_reg12");
        end_test("codec register access");

        // 3 16-bit stereo, no attenuation
        write_codec(REG_FORMAT, 8'h50);
        write_codec(REG_LEFT_DAC, 8'h00);
        write_codec(REG_RIGHT_DAC, 8'h00);
        write_status(8'h14);  // FIFO_CODEC and FIFO_PLAY
        sync_outputs();
        make_frames(6);
        fork
            feed_fifo();
            check_frames(6);
        join
        end_test("16-bit stereo playback");

        // 4 8-bit mono, random attenuation per channel
        write_codec(REG_FORMAT, 8'h00);
        val = $random(seed);
        write_codec(REG_LEFT_DAC, val & 8'h3f);
        val = $random(seed);
        write_codec(REG_RIGHT_DAC, val & 8'h3f);
        sync_outputs();
        make_frames(8);
        fork
            feed_fifo();
            check_frames(8);
        join
        end_test("8-bit mono with attenuation");

        // 5 FIFO_PLAY cleared, both channels muted
        write_status(8'h04);
        sync_outputs();
        check_value("out_left", 32'd0, out_left);
        check_value("out_right", 32'd0, out_right);
        end_test("play off mutes outputs");

        // 6 play interrupt with an empty FIFO
        check_value("toc_int", 32'd0, toc_int);
        write_status(8'h94);  // PLAY_INTENA, FIFO_PLAY, FIFO_CODEC
        sync_outputs();
        if (model_status[STATUS_FIFO_PLAY] && model_status[STATUS_PLAY_INTENA] &&
            byte_q.size() <= FIFO_DEPTH / 2) begin
            model_irq[IRQ_PLAY_HALF] = 1'b1;
        end
        model_irq[IRQ_INT_N] = ~|model_irq[6:0];
        wait_toc_int(1'b1);
        read_expect(ADDR_STATUS, {model_irq, model_irq}, "irq");
        wait_toc_int(1'b0);  // Cleared once sel falls
        end_test("half-empty interrupt");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
rtl/toccata_pkg.sv
rtl/byte_stream_if.sv
rtl/toccata_sample_fifo.sv
rtl/toccata_playback.sv
rtl/toccata_volume.sv
rtl/toccata_bus_regs.sv
rtl/toccata_top.sv
dv/tb_clkgen.sv
dv/tb_toccata.sv

/* rtl/byte_stream_if.sv */
// ==============================
// Byte stream link
// Valid/ready bytes plus a flush strobe
// ==============================
`timescale 1ns/1ps

interface byte_stream_if;

    logic       valid;  // Byte on data
    logic       ready;  // Sink accepts this cycle
    logic [7:0] data;
    logic       flush;  // Empty the buffer, beats a write

    modport source (
        output valid,
        output data,
        output flush,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  flush,
        output ready
    );

endinterface

/* rtl/toccata_bus_regs.sv */
// ==============================
// Toccata bus register block
// Status, IRQ, codec registers, FIFO byte writer
// ==============================
`timescale 1ns/1ps

module toccata_bus_regs (
    input  logic          clk,
    input  logic          rst,
    input  logic [15:0]   data_in,
    output logic [15:0]   data_out,
    input  logic [15:1]   addr,
    input  logic          rd,
    input  logic          hwr,
    input  logic          lwr,
    input  logic          sel,
    output logic          toc_int,
    byte_stream_if.source wr_stream,
    input  logic          fifo_empty,
    input  logic          fifo_half_empty,
    output logic          pen,
    output logic          format_16,
    output logic          stereo,
    output logic [5:0]    atten_left,
    output logic [5:0]    atten_right,
    output logic          mute_left,
    output logic          mute_right
);
    import toccata_pkg::*;

    bus_region_e region;
    logic [7:0]  din_byte;       // Byte from the active lane
    logic        lwr_q;          // Edge detect
    logic        hwr_q;
    logic        play_on;        // Play enable from a status byte
    logic [7:0]  index_reg;
    logic [7:0]  codec_regs [CODEC_REG_COUNT];
    logic [7:0]  status;
    logic [7:0]  irq;
    logic        clear_irq;      // Status read seen, clear when sel drops
    logic        hi_pending;     // High byte queued behind the low byte
    logic [7:0]  hi_byte;

    assign region   = bus_region_e'({addr[14], addr[13], addr[11]});
    assign din_byte = lwr ? data_in[7:0] : data_in[15:8];  // Low lane wins
    assign play_on  = din_byte[STATUS_FIFO_CODEC] & din_byte[STATUS_FIFO_PLAY];

    // Fields decoded for playback and volume
    assign pen         = codec_regs[REG_IFACE][0];
    assign stereo      = codec_regs[REG_FORMAT][4];
    assign format_16   = codec_regs[REG_FORMAT][6];
    assign atten_left  = codec_regs[REG_LEFT_DAC][5:0];
    assign mute_left   = codec_regs[REG_LEFT_DAC][7];
    assign atten_right = codec_regs[REG_RIGHT_DAC][5:0];
    assign mute_right  = codec_regs[REG_RIGHT_DAC][7];

    always_ff @(posedge clk) begin
        lwr_q <= lwr;
        hwr_q <= hwr;
        if (rst) begin
            for (int i = 0; i < CODEC_REG_COUNT; i++) begin
                codec_regs[i] <= CODEC_RESET_VALUES[i];
            end
            index_reg       <= CODEC_INDEX_RESET;
            status          <= '0;
            irq             <= IRQ_IDLE;
            clear_irq       <= 1'b0;
            toc_int         <= 1'b0;
            data_out        <= '0;
            hi_pending      <= 1'b0;
            wr_stream.valid <= 1'b0;
            wr_stream.flush <= 1'b1;  // Start with an empty FIFO
        end else begin
            wr_stream.valid <= 1'b0;
            wr_stream.flush <= 1'b0;
            hi_pending      <= 1'b0;
            toc_int         <= !irq[IRQ_INT_N];
            codec_regs[REG_TEST][6] <= fifo_empty;  // Underrun flag

            // ==============================
            // Interrupt sources
            // ==============================
            if (fifo_half_empty && status[STATUS_FIFO_PLAY] && status[STATUS_PLAY_INTENA]) begin
                irq[IRQ_PLAY_HALF] <= 1'b1;
            end
            irq[IRQ_INT_N] <= !(|irq[6:0]);

            if (hi_pending) begin  // Second byte of a word write
                wr_stream.valid <= 1'b1;
                wr_stream.data  <= hi_byte;
            end

            // ==============================
            // Host access
            // ==============================
            if (!sel) begin
                data_out <= '0;
                if (clear_irq) begin
                    irq       <= IRQ_IDLE;
                    clear_irq <= 1'b0;
                end
            end else if (lwr || hwr) begin
                case (region)
                    REGION_STATUS: begin
                        if (din_byte[STATUS_RESET]) begin  // Stop card
                            status          <= '0;
                            wr_stream.flush <= 1'b1;
                            irq             <= IRQ_IDLE;
                            codec_regs[REG_IFACE][0] <= 1'b0;
                        end else begin
                            status <= din_byte;
                            if (din_byte == 8'h01) begin  // Exact match only
                                wr_stream.flush <= 1'b1;
                                irq             <= IRQ_IDLE;
                            end
                            codec_regs[REG_IFACE][0]     <= play_on;
                            codec_regs[REG_LEFT_DAC][7]  <= !play_on;  // Unmute on play
                            codec_regs[REG_RIGHT_DAC][7] <= !play_on;
                        end
                    end
                    REGION_FIFO: begin
                        if (lwr && !lwr_q) begin
                            wr_stream.valid <= 1'b1;
                            wr_stream.data  <= data_in[7:0];
                        end
                        if (hwr && !hwr_q) begin
                            hi_pending <= 1'b1;
                            hi_byte    <= data_in[15:8];
                        end
                        irq[IRQ_PLAY_HALF] <= 1'b0;  // Host is refilling
                    end
                    REGION_INDEX: begin
                        if (lwr) index_reg <= data_in[7:0];
                    end
                    REGION_CODEC: begin
                        if (lwr && index_reg[3:0] != 4'd12) begin  // Reg 12 read only
                            codec_regs[index_reg[3:0]] <= data_in[7:0];
                        end
                    end
                    default: ;
                endcase
            end else if (rd) begin
                case (region)
                    REGION_STATUS: begin
                        data_out  <= {irq, irq};
                        clear_irq <= 1'b1;
                    end
                    REGION_INDEX: data_out <= {8'h00, index_reg};
                    REGION_CODEC: data_out <= {8'h00, codec_regs[index_reg[3:0]]};
                    default:      data_out <= '0;  // FIFO is write only
                endcase
            end
        end
    end

endmodule

/* rtl/toccata_pkg.sv */
// ==============================
// Toccata shared definitions
// Bus regions, codec register map and bit positions
// ==============================
package toccata_pkg;

    // Region select from addr[14], addr[13], addr[11]
    typedef enum logic [2:0] {
        REGION_STATUS = 3'b000,  // 0x0000
        REGION_FIFO   = 3'b010,  // 0x2000-0x27ff
        REGION_INDEX  = 3'b110,  // 0x6000-0x67ff
        REGION_CODEC  = 3'b111   // 0x6800 and up
    } bus_region_e;

    typedef enum logic [1:0] {
        PLAY_IDLE,   // Playback disabled
        PLAY_FETCH,  // Collecting frame bytes
        PLAY_HOLD    // Frame complete, waiting for tick
    } play_state_e;

    typedef logic signed [15:0] sample_t;  // Two's complement audio

    // AD1848 indirect register file
    localparam int CODEC_REG_COUNT = 16;
    localparam logic [7:0] CODEC_RESET_VALUES [CODEC_REG_COUNT] = '{
        8'h00, 8'h00, 8'h00, 8'h80,  // Regs 3 to 5 aux input, muted
        8'h80, 8'h80, 8'h80, 8'h80,  // Regs 6 and 7 DAC, muted
        8'h00, 8'h10, 8'h00, 8'h00,  // Reg 9 interface config
        8'h0a, 8'h00, 8'h00, 8'h00   // Reg 12 misc, read only
    };
    localparam logic [7:0] CODEC_INDEX_RESET = 8'h40;

    localparam int REG_LEFT_DAC  = 6;
    localparam int REG_RIGHT_DAC = 7;
    localparam int REG_FORMAT    = 8;   // Bit 4 stereo, bit 6 16-bit
    localparam int REG_IFACE     = 9;   // Bit 0 playback enable
    localparam int REG_TEST      = 11;  // Bit 6 underrun

    // Card status register
    localparam int STATUS_RESET       = 1;
    localparam int STATUS_FIFO_CODEC  = 2;
    localparam int STATUS_FIFO_PLAY   = 4;
    localparam int STATUS_PLAY_INTENA = 7;

    // IRQ register, read at the status address
    localparam int IRQ_PLAY_HALF = 3;
    localparam int IRQ_INT_N     = 7;  // Active low summary
    localparam logic [7:0] IRQ_IDLE = 8'h80;

endpackage

/* rtl/toccata_playback.sv */
// ==============================
// Toccata playback engine
// Rate tick and frame assembly from FIFO bytes
// ==============================
`timescale 1ns/1ps

module toccata_playback #(
    parameter int SAMPLE_DIV = 642
) (
    input  logic                 clk,
    input  logic                 rst,
    byte_stream_if.sink          rd_stream,
    input  logic                 pen,
    input  logic                 format_16,
    input  logic                 stereo,
    output toccata_pkg::sample_t sample_left,
    output toccata_pkg::sample_t sample_right
);
    import toccata_pkg::*;

    localparam int DIV_W = $clog2(SAMPLE_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    play_state_e      state;
    logic [1:0]       byte_cnt;   // Next frame slot
    logic [1:0]       last_byte;  // Frame length minus one
    logic [7:0]       frame [4];  // L lo, L hi, R lo, R hi
    sample_t          left_word;
    sample_t          right_word;

    // Unsigned 8-bit to signed 16-bit
    function automatic sample_t widen(input logic [7:0] b);
        return {~b[7], b[6:0], 8'h00};
    endfunction

    assign tick      = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
    assign last_byte = {format_16 & stereo, format_16 | stereo};  // 0, 1 or 3
    assign rd_stream.ready = (state == PLAY_FETCH);

    always_comb begin
        if (format_16) begin
            left_word  = {frame[1], frame[0]};  // Low byte first
            right_word = stereo ? {frame[3], frame[2]} : left_word;
        end else begin
            left_word  = widen(frame[0]);
            right_word = stereo ? widen(frame[1]) : left_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt      <= '0;
            state        <= PLAY_IDLE;
            byte_cnt     <= '0;
            sample_left  <= '0;
            sample_right <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (!pen || rd_stream.flush) begin  // Drop any partial frame
                state    <= PLAY_IDLE;
                byte_cnt <= '0;
            end else begin
                case (state)
                    PLAY_IDLE: state <= PLAY_FETCH;
                    PLAY_FETCH: begin
                        if (rd_stream.valid) begin
                            frame[byte_cnt] <= rd_stream.data;
                            byte_cnt        <= (byte_cnt == last_byte) ? 2'd0 : byte_cnt + 1'b1;
                            if (byte_cnt == last_byte) state <= PLAY_HOLD;
                        end
                    end
                    PLAY_HOLD: begin
                        if (tick) begin  // Underrun just keeps the old frame
                            sample_left  <= left_word;
                            sample_right <= right_word;
                            state        <= PLAY_FETCH;
                        end
                    end
                    default: state <= PLAY_IDLE;
                endcase
            end
        end
    end

endmodule

/* rtl/toccata_sample_fifo.sv */
// ==============================
// Toccata sample FIFO
// Circular byte buffer with level flags
// ==============================
`timescale 1ns/1ps

module toccata_sample_fifo #(
    parameter int FIFO_DEPTH = 1024  // Power of two, pointers wrap
) (
    input  logic          clk,
    input  logic          rst,
    byte_stream_if.sink   wr_stream,
    byte_stream_if.source rd_stream,
    output logic          empty,
    output logic          half_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;    // Bytes stored
    logic          push;
    logic          pop;

    assign wr_stream.ready = (level != FIFO_DEPTH);
    assign push = wr_stream.valid && wr_stream.ready && !wr_stream.flush;
    assign pop  = rd_stream.valid && rd_stream.ready;

    assign empty           = (level == '0);
    assign half_empty      = (level <= FIFO_DEPTH / 2);
    assign rd_stream.valid = !empty;
    assign rd_stream.data  = mem[rd_ptr];     // Head byte
    assign rd_stream.flush = wr_stream.flush; // Drop partial frames too

    always_ff @(posedge clk) begin
        if (rst || wr_stream.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= wr_stream.data;
    end

endmodule

/* rtl/toccata_top.sv */
// ==============================
// Toccata playback top
// Zorro II registers, sample FIFO, playback, volume
// ==============================
`timescale 1ns/1ps

module toccata_top #(
    parameter int FIFO_DEPTH = 1024,  // Power of two
    parameter int SAMPLE_DIV = 642    // Clocks per sample frame
) (
    input  logic                 clk,
    input  logic                 rst,
    // Zorro II side
    input  logic [15:0]          data_in,
    output logic [15:0]          data_out,
    input  logic [15:1]          addr,
    input  logic                 rd,
    input  logic                 hwr,
    input  logic                 lwr,
    input  logic                 sel,
    output logic                 toc_int,    // Active high
    // Audio out
    output toccata_pkg::sample_t out_left,
    output toccata_pkg::sample_t out_right
);
    import toccata_pkg::*;

    byte_stream_if wr_stream ();  // Bus block to FIFO
    byte_stream_if rd_stream ();  // FIFO to playback

    logic       fifo_empty;
    logic       fifo_half_empty;
    logic       pen;
    logic       format_16;
    logic       stereo;
    logic [5:0] atten_left;
    logic [5:0] atten_right;
    logic       mute_left;
    logic       mute_right;
    sample_t    sample_left;
    sample_t    sample_right;

    toccata_bus_regs i_bus_regs (
        .clk             (clk),
        .rst             (rst),
        .data_in         (data_in),
        .data_out        (data_out),
        .addr            (addr),
        .rd              (rd),
        .hwr             (hwr),
        .lwr             (lwr),
        .sel             (sel),
        .toc_int         (toc_int),
        .wr_stream       (wr_stream.source),
        .fifo_empty      (fifo_empty),
        .fifo_half_empty (fifo_half_empty),
        .pen             (pen),
        .format_16       (format_16),
        .stereo          (stereo),
        .atten_left      (atten_left),
        .atten_right     (atten_right),
        .mute_left       (mute_left),
        .mute_right      (mute_right)
    );

    toccata_sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_sample_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_stream  (wr_stream.sink),
        .rd_stream  (rd_stream.source),
        .empty      (fifo_empty),
        .half_empty (fifo_half_empty)
    );

    toccata_playback #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) i_playback (
        .clk          (clk),
        .rst          (rst),
        .rd_stream    (rd_stream.sink),
        .pen          (pen),
        .format_16    (format_16),
        .stereo       (stereo),
        .sample_left  (sample_left),
        .sample_right (sample_right)
    );

    toccata_volume i_volume (
        .clk          (clk),
        .rst          (rst),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .atten_left   (atten_left),
        .atten_right  (atten_right),
        .mute_left    (mute_left),
        .mute_right   (mute_right),
        .out_left     (out_left),
        .out_right    (out_right)
    );

endmodule

/* rtl/toccata_volume.sv */
// ==============================
// Toccata output volume
// Per-channel attenuation and mute
// ==============================
`timescale 1ns/1ps

module toccata_volume (
    input  logic                 clk,
    input  logic                 rst,
    input  toccata_pkg::sample_t sample_left,
    input  toccata_pkg::sample_t sample_right,
    input  logic [5:0]           atten_left,   // 1.5 dB steps
    input  logic [5:0]           atten_right,
    input  logic                 mute_left,
    input  logic                 mute_right,
    output toccata_pkg::sample_t out_left,
    output toccata_pkg::sample_t out_right
);
    import toccata_pkg::*;

    sample_t left_att;
    sample_t right_att;

    // About 6 dB per shift, lower two attenuation bits ignored
    assign left_att  = sample_left >>> atten_left[5:2];
    assign right_att = sample_right >>> atten_right[5:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_left  <= '0;
            out_right <= '0;
        end else begin
            if (mute_left) out_left <= '0;
            else           out_left <= left_att;
            if (mute_right) out_right <= '0;
            else            out_right <= right_att;
        end
    end

endmodule
